// ==== rbz_top.f ====
+incdir+dv
logic/rbz_video_pkg.sv
logic/rbz_tex_pkg.sv
logic/rbz_vga_timing.sv
logic/rbz_tex_fetch_fsm.sv
logic/rbz_texel_buffer.sv
logic/rbz_column_render.sv
logic/rbz_top.sv
dv/rbz_tb.sv

// ==== dv/rbz_tb_model.svh ====
`ifndef RBZ_TB_MODEL_SVH
`define RBZ_TB_MODEL_SVH

// Raster position the model expects in the current cycle
int m_h;
int m_v;
// Nibbles seen on the flash lines during this line's read window
logic [3:0] nib_line [TSPI_READ_LEN];
// Texels and slice drawn on the current line
rgb_t tex_act [TEXEL_COUNT];
int size_act;
int texa_act;
int init_act;
// Slice sampled in the last cycle before the stream
int size_pend;
int texa_pend;
int init_pend;
tex_addr_t addr_pend;
int wall_checks;

task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
  if (actual !== expected) begin
    $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
    $display("TEST FAIL");
    $fatal(1, "Mismatch on %s", name);
  end
endtask

// Base plus wall, side and texu offset, wrapped to 24 bits
function automatic tex_addr_t slice_address(tex_addr_t base, int wall, int side, int texu);
  return tex_addr_t'(base + wall * 2048 + side * 1024 + texu * 64);
endfunction

// Bit idx of the command byte followed by the address, MSB first
function automatic logic stream_bit(tex_addr_t addr, int idx);
  logic [31:0] word;
  word = {8'h6B, addr};
  return word[31 - idx];
endfunction

// Even nibble gives the LSBs, odd nibble the MSBs, colours packed BBGGRR
function automatic rgb_t texel_color(logic [3:0] n0, logic [3:0] n1);
  return {n1[2], n0[2], n1[1], n0[1], n1[0], n0[0]};
endfunction

function automatic logic in_span(int h);
  return (h >= HALF_VIEW - size_act) && (h < HALF_VIEW + size_act);
endfunction

function automatic rgb_t pixel_color(int h, int v, rgb_t floor_c, rgb_t sky_c);
  int texv;
  if (h >= H_VIEW || v >= V_VIEW) begin
    return '0;
  end
  if (in_span(h)) begin
    // Integer part of init plus h steps, 10 fraction bits
    texv = ((init_act + h * texa_act) % 65536) / 1024;
    return tex_act[texv];
  end
  return (h < HALF_VIEW) ? floor_c : sky_c;
endfunction

// Follows slice sampling, nibble capture and the line swap
task automatic track_line();
  if (m_h == TSPI_HPOS_START - 1) begin
    size_pend = i_size;
    texa_pend = i_texa;
    init_pend = i_texv_init;
    addr_pend = slice_address(i_tex_base, i_wall, i_side, i_texu);
  end
  if (m_h >= H_VIEW && m_h < H_VIEW + TSPI_READ_LEN) begin
    nib_line[m_h - H_VIEW] = i_tex_in;
  end
  // Fetched slice becomes the one drawn on the next line
  if (m_h == H_TOTAL - 1) begin
    size_act = size_pend;
    texa_act = texa_pend;
    init_act = init_pend;
    for (int t = 0; t < TEXEL_COUNT; t++) begin
      tex_act[t] = texel_color(nib_line[2 * t], nib_line[2 * t + 1]);
    end
  end
endtask

task automatic advance_raster();
  if (m_h == H_TOTAL - 1) begin
    m_h = 0;
    m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
  end else begin
    m_h = m_h + 1;
  end
endtask

`endif

// ==== dv/rbz_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rbz_tb
  import rbz_video_pkg::*;
  import rbz_tex_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int RUN_CYCLES  = 2 * H_TOTAL * V_TOTAL;
  // Two frames plus 10% margin
  localparam int WATCHDOG_NS = RUN_CYCLES * CLK_PERIOD / 10 * 11;

  logic       clk;
  logic       i_reset;
  wall_id_t   i_wall;
  logic       i_side;
  texel_idx_t i_texu;
  span_t      i_size;
  texv_acc_t  i_texa;
  texv_acc_t  i_texv_init;
  tex_addr_t  i_tex_base;
  rgb_t       i_floor;
  rgb_t       i_sky;
  logic [3:0] i_tex_in;
  logic       o_tex_csb;
  logic       o_tex_sclk;
  logic       o_tex_out0;
  logic       o_tex_oeb0;
  logic       o_hsync_n;
  logic       o_vsync_n;
  logic       o_hblank;
  logic       o_vblank;
  logic       o_hmax;
  pos_t       o_hpos;
  pos_t       o_vpos;
  rgb_t       o_rgb;
  integer     seed = 32'hff11ed4f;

  `include "rbz_tb_model.svh"

  rbz_top dut_i (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_wall      (i_wall),
    .i_side      (i_side),
    .i_texu      (i_texu),
    .i_size      (i_size),
    .i_texa      (i_texa),
    .i_texv_init (i_texv_init),
    .i_tex_base  (i_tex_base),
    .i_floor     (i_floor),
    .i_sky       (i_sky),
    .i_tex_in    (i_tex_in),
    .o_tex_csb   (o_tex_csb),
    .o_tex_sclk  (o_tex_sclk),
    .o_tex_out0  (o_tex_out0),
    .o_tex_oeb0  (o_tex_oeb0),
    .o_hsync_n   (o_hsync_n),
    .o_vsync_n   (o_vsync_n),
    .o_hblank    (o_hblank),
    .o_vblank    (o_vblank),
    .o_hmax      (o_hmax),
    .o_hpos      (o_hpos),
    .o_vpos      (o_vpos),
    .o_rgb       (o_rgb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // New slice for the next fetch
  task automatic randomize_slice();
    logic [31:0] r;
    r = $random(seed);
    i_wall <= r[1:0];
    i_side <= r[2];
    i_texu <= r[8:3];
    r = $random(seed);
    // Half-heights from none up to wider than the view
    i_size <= span_t'(r % 340);
    r = $random(seed);
    i_texa      <= r[15:0];
    i_texv_init <= r[31:16];
  endtask

  task automatic randomize_frame();
    logic [31:0] r;
    r = $random(seed);
    i_floor <= r[5:0];
    i_sky   <= r[11:6];
    r = $random(seed);
    i_tex_base <= r[23:0];
  endtask

  // Slice, frame and flash stimulus
  always @(posedge clk) begin
    if (!i_reset) begin
      if (o_hpos == 700) randomize_slice();
      // Frame values change inside vblank
      if (o_hpos == 700 && o_vpos == V_VIEW + 5) randomize_frame();
      // Flash answers with a fresh nibble for each read cycle
      if (o_hpos >= H_VIEW - 1 && o_hpos < H_VIEW + TSPI_READ_LEN - 1) begin
        i_tex_in <= 4'($random(seed));
      end else begin
        i_tex_in <= 4'h0;
      end
    end
  end

  task automatic check_outputs();
    logic in_window;
    int   addr_end;
    in_window = (m_h >= TSPI_HPOS_START) && (m_h < TSPI_HPOS_START + TSPI_STREAM_LEN);
    addr_end  = TSPI_HPOS_START + TSPI_CMD_LEN + TSPI_ADDR_LEN;
    check_value("hpos", m_h, o_hpos);
    check_value("vpos", m_v, o_vpos);
    check_value("hsync_n", !(m_h >= H_SYNC_START && m_h < H_SYNC_END), o_hsync_n);
    check_value("vsync_n", !(m_v >= V_SYNC_START && m_v < V_SYNC_END), o_vsync_n);
    check_value("hblank", m_h >= H_VIEW, o_hblank);
    check_value("vblank", m_v >= V_VIEW, o_vblank);
    check_value("hmax", m_h == H_TOTAL - 1, o_hmax);
    check_value("tex_csb", !in_window, o_tex_csb);
    // io0 released for dummy and read cycles
    check_value("tex_oeb0", in_window && m_h >= H_VIEW - TSPI_DUMMY_LEN, o_tex_oeb0);
    if (m_h >= TSPI_HPOS_START && m_h < addr_end) begin
      check_value("tex_out0", stream_bit(addr_pend, m_h - TSPI_HPOS_START), o_tex_out0);
    end else begin
      check_value("tex_out0 idle", 0, o_tex_out0);
    end
    if (m_h < H_VIEW && m_v < V_VIEW && in_span(m_h)) wall_checks++;
    check_value($sformatf("rgb at %0d,%0d", m_h, m_v),
                pixel_color(m_h, m_v, i_floor, i_sky), o_rgb);
  endtask

  // Outputs compared mid-cycle where everything is settled
  always @(negedge clk) begin
    if (i_reset) begin
      m_h = 0;
      m_v = 0;
      size_act = 0;
    end else begin
      check_outputs();
      track_line();
      advance_raster();
    end
  end

  // Flash clock follows the inverted clk, looked at a quarter period after each edge
  always @(clk) begin
    #(CLK_PERIOD / 4);
    check_value("tex_sclk", !clk, o_tex_sclk);
  end

  initial begin
    i_reset  = 1'b1;
    i_tex_in = 4'h0;
    randomize_slice();
    randomize_frame();
    repeat (3) @(posedge clk);
    i_reset <= 1'b0;
    @(negedge clk);
    check_value("reset tex_csb", 1, o_tex_csb);
    check_value("reset tex_oeb0", 0, o_tex_oeb0);
    check_value("reset hsync_n", 1, o_hsync_n);
    check_value("reset vsync_n", 1, o_vsync_n);
    repeat (RUN_CYCLES) @(posedge clk);
    if (wall_checks == 0) begin
      $display("No wall pixel was drawn during the run");
      $display("TEST FAIL");
      $fatal(1, "Wall rendering was never exercised");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before two frames completed");
    $display("TEST FAIL");
    $fatal(1, "Simulation timeout");
  end

endmodule

`default_nettype wire

// ==== logic/rbz_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rbz_top
  import rbz_video_pkg::*;
  import rbz_tex_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  wall_id_t   i_wall,
  input  logic       i_side,
  input  texel_idx_t i_texu,
  input  span_t      i_size,
  input  texv_acc_t  i_texa,
  input  texv_acc_t  i_texv_init,
  input  tex_addr_t  i_tex_base,
  input  rgb_t       i_floor,
  input  rgb_t       i_sky,
  input  logic [3:0] i_tex_in,
  output logic       o_tex_csb,
  output logic       o_tex_sclk,
  output logic       o_tex_out0,
  output logic       o_tex_oeb0,
  output logic       o_hsync_n,
  output logic       o_vsync_n,
  output logic       o_hblank,
  output logic       o_vblank,
  output logic       o_hmax,
  output pos_t       o_hpos,
  output pos_t       o_vpos,
  output rgb_t       o_rgb
);

  // Fetch to buffer and renderer
  logic       fetch_start;
  logic       capture;
  logic       odd_nibble;
  texel_idx_t texv;
  rgb_t       texel;

  rbz_vga_timing vga_timing_i (
    .clk       (clk),
    .i_reset   (i_reset),
    .o_hpos    (o_hpos),
    .o_vpos    (o_vpos),
    .o_hsync_n (o_hsync_n),
    .o_vsync_n (o_vsync_n),
    .o_hblank  (o_hblank),
    .o_vblank  (o_vblank),
    .o_hmax    (o_hmax)
  );

  // Reads next line's slice during the end of this line
  rbz_tex_fetch_fsm tex_fetch_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_hpos        (o_hpos),
    .i_wall        (i_wall),
    .i_side        (i_side),
    .i_texu        (i_texu),
    .i_tex_base    (i_tex_base),
    .o_tex_csb     (o_tex_csb),
    .o_tex_sclk    (o_tex_sclk),
    .o_tex_out0    (o_tex_out0),
    .o_tex_oeb0    (o_tex_oeb0),
    .o_fetch_start (fetch_start),
    .o_capture     (capture),
    .o_odd_nibble  (odd_nibble)
  );

  rbz_texel_buffer texel_buf_i (
    .clk          (clk),
    .i_capture    (capture),
    .i_odd_nibble (odd_nibble),
    .i_tex_in     (i_tex_in),
    .i_texv       (texv),
    .o_texel      (texel)
  );

  rbz_column_render render_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_hpos        (o_hpos),
    .i_hblank      (o_hblank),
    .i_vblank      (o_vblank),
    .i_hmax        (o_hmax),
    .i_fetch_start (fetch_start),
    .i_size        (i_size),
    .i_texa        (i_texa),
    .i_texv_init   (i_texv_init),
    .i_floor       (i_floor),
    .i_sky         (i_sky),
    .i_texel       (texel),
    .o_texv        (texv),
    .o_rgb         (o_rgb)
  );

endmodule

`default_nettype wire

// ==== logic/rbz_column_render.sv ====
`timescale 1ns/1ps
`default_nettype none

module rbz_column_render
  import rbz_video_pkg::*;
  import rbz_tex_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  pos_t       i_hpos,
  input  logic       i_hblank,
  input  logic       i_vblank,
  input  logic       i_hmax,
  input  logic       i_fetch_start,
  input  span_t      i_size,
  input  texv_acc_t  i_texa,
  input  texv_acc_t  i_texv_init,
  input  rgb_t       i_floor,
  input  rgb_t       i_sky,
  input  rgb_t       i_texel,
  output texel_idx_t o_texv,
  output rgb_t       o_rgb
);

  // Slice captured alongside the flash fetch
  span_t     size_pend;
  texv_acc_t texa_pend;
  texv_acc_t init_pend;
  // Slice being drawn on the current line
  span_t     size_act;
  texv_acc_t texa_act;
  texv_acc_t texv_acc;
  logic      span_left_ok;
  logic      span_right_ok;
  logic      in_wall;

  // Size is reset so no wall shows before the first fetch
  always_ff @(posedge clk) begin
    if (i_reset) begin
      size_pend <= '0;
      size_act  <= '0;
    end else begin
      if (i_fetch_start) size_pend <= i_size;
      if (i_hmax) size_act <= size_pend;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetch_start) begin
      texa_pend <= i_texa;
      init_pend <= i_texv_init;
    end
    if (i_hmax) begin
      texa_act <= texa_pend;
    end
  end

  // Holds init plus hpos times texa along the line
  always_ff @(posedge clk) begin
    if (i_hmax) begin
      texv_acc <= init_pend;
    end else begin
      texv_acc <= texv_acc + texa_act;
    end
  end

  // Integer part of the accumulator
  assign o_texv = texv_acc[TEXV_FRAC_BITS +: $bits(texel_idx_t)];

  // Span test done in 11 bits so 320 minus size cannot wrap
  assign span_left_ok  = ({1'b0, i_hpos} + {1'b0, size_act}) >= 11'(HALF_VIEW);
  assign span_right_ok = {1'b0, i_hpos} < (11'(HALF_VIEW) + {1'b0, size_act});
  assign in_wall       = span_left_ok && span_right_ok;

  // Final colour mux
  always_comb begin
    if (i_hblank || i_vblank) begin
      o_rgb = '0;
    end else if (in_wall) begin
      o_rgb = i_texel;
    end else if (i_hpos < pos_t'(HALF_VIEW)) begin
      // Floor on the left half
      o_rgb = i_floor;
    end else begin
      o_rgb = i_sky;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rbz_texel_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rbz_texel_buffer
  import rbz_video_pkg::*;
  import rbz_tex_pkg::*;
(
  input  logic       clk,
  input  logic       i_capture,
  input  logic       i_odd_nibble,
  input  logic [3:0] i_tex_in,
  input  texel_idx_t i_texv,
  output rgb_t       o_texel
);

  // One LSB and one MSB plane per colour, index 0 red, 1 green, 2 blue
  logic [TEXEL_COUNT-1:0] lsb_q [3];
  logic [TEXEL_COUNT-1:0] msb_q [3];

  // Nibbles enter at the top so the first texel ends up at index 0
  // io3 carries no colour data
  always_ff @(posedge clk) begin
    if (i_capture) begin
      for (int c = 0; c < 3; c++) begin
        if (i_odd_nibble) begin
          msb_q[c] <= {i_tex_in[c], msb_q[c][TEXEL_COUNT-1:1]};
        end else begin
          lsb_q[c] <= {i_tex_in[c], lsb_q[c][TEXEL_COUNT-1:1]};
        end
      end
    end
  end

  // Lookup by texv, packed as BBGGRR
  assign o_texel = {
    msb_q[2][i_texv], lsb_q[2][i_texv],
    msb_q[1][i_texv], lsb_q[1][i_texv],
    msb_q[0][i_texv], lsb_q[0][i_texv]
  };

  // Back-to-back captures alternate between LSB and MSB planes
  a_parity_toggle: assert property (@(posedge clk)
    (i_capture && $past(i_capture)) |-> (i_odd_nibble != $past(i_odd_nibble)));

endmodule

`default_nettype wire

// ==== logic/rbz_tex_fetch_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module rbz_tex_fetch_fsm
  import rbz_video_pkg::*;
  import rbz_tex_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  pos_t       i_hpos,
  input  wall_id_t   i_wall,
  input  logic       i_side,
  input  texel_idx_t i_texu,
  input  tex_addr_t  i_tex_base,
  output logic       o_tex_csb,
  output logic       o_tex_sclk,
  output logic       o_tex_out0,
  output logic       o_tex_oeb0,
  output logic       o_fetch_start,
  output logic       o_capture,
  output logic       o_odd_nibble
);

  tspi_phase_e state;
  logic [7:0]  bit_cnt;
  logic [7:0]  phase_len;
  logic        phase_done;
  logic [31:0] shift_q;
  tex_addr_t   slice_addr;

  // Flash samples out0 on the rising sclk edge, half a clk after it changes
  assign o_tex_sclk = ~clk;

  // Slice offset above the base, wall steps 2048, side 1024 and texu 64
  assign slice_addr = i_tex_base
                    + {11'd0, i_wall, 11'd0}
                    + {13'd0, i_side, 10'd0}
                    + {12'd0, i_texu, 6'd0};

  // Strobe during the last pixel before the stream window
  assign o_fetch_start = (state == IDLE) && (i_hpos == pos_t'(TSPI_HPOS_START - 1));

  // Length of the current phase
  always_comb begin
    unique case (state)
      CMD:     phase_len = 8'(TSPI_CMD_LEN);
      ADDR:    phase_len = 8'(TSPI_ADDR_LEN);
      DUMMY:   phase_len = 8'(TSPI_DUMMY_LEN);
      READ:    phase_len = 8'(TSPI_READ_LEN);
      default: phase_len = 8'd1;
    endcase
  end

  assign phase_done = (bit_cnt == phase_len - 1'b1);

  // Phase sequencer
  always_ff @(posedge clk) begin
    if (i_reset) begin
      state   <= IDLE;
      bit_cnt <= '0;
    end else begin
      // Counter restarts at each phase boundary
      if (state == IDLE || phase_done) begin
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      unique case (state)
        IDLE:    if (o_fetch_start) state <= CMD;
        CMD:     if (phase_done) state <= ADDR;
        ADDR:    if (phase_done) state <= DUMMY;
        DUMMY:   if (phase_done) state <= READ;
        READ:    if (phase_done) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Command and address go out MSB first from one shift register
  always_ff @(posedge clk) begin
    if (o_fetch_start) begin
      shift_q <= {QUAD_OUT_FAST_READ, slice_addr};
    end else if (state == CMD || state == ADDR) begin
      shift_q <= {shift_q[30:0], 1'b0};
    end
  end

  // Chip selected for the whole stream
  assign o_tex_csb    = (state == IDLE);
  assign o_tex_out0   = (state == CMD || state == ADDR) ? shift_q[31] : 1'b0;
  // io0 turns around once the address is out
  assign o_tex_oeb0   = (state == DUMMY || state == READ);
  assign o_capture    = (state == READ);
  // Even nibble holds colour LSBs, odd nibble the MSBs
  assign o_odd_nibble = bit_cnt[0];

  // Stream ends on the raster, csb rises at the end of the window
  a_csb_release: assert property (@(posedge clk) disable iff (i_reset)
    (state == READ && phase_done) |=>
      (o_tex_csb && i_hpos == pos_t'(TSPI_HPOS_START + TSPI_STREAM_LEN)));

  // No flash traffic outside the stream window
  a_idle_outside: assert property (@(posedge clk) disable iff (i_reset)
    (i_hpos < pos_t'(TSPI_HPOS_START) ||
     i_hpos >= pos_t'(TSPI_HPOS_START + TSPI_STREAM_LEN)) |-> (state == IDLE));

endmodule

`default_nettype wire

// ==== logic/rbz_vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module rbz_vga_timing
  import rbz_video_pkg::*;
(
  input  logic clk,
  input  logic i_reset,
  output pos_t o_hpos,
  output pos_t o_vpos,
  output logic o_hsync_n,
  output logic o_vsync_n,
  output logic o_hblank,
  output logic o_vblank,
  output logic o_hmax
);

  pos_t hpos_next;
  pos_t vpos_next;
  logic line_end;

  // Last pixel clock of the line
  assign line_end = (o_hpos == pos_t'(H_TOTAL - 1));

  // Next raster position
  always_comb begin
    hpos_next = line_end ? '0 : o_hpos + 1'b1;
    vpos_next = o_vpos;
    if (line_end) begin
      vpos_next = (o_vpos == pos_t'(V_TOTAL - 1)) ? '0 : o_vpos + 1'b1;
    end
  end

  // Flags are decoded from the next position so they line up with hpos/vpos
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_hpos    <= '0;
      o_vpos    <= '0;
      o_hsync_n <= 1'b1;
      o_vsync_n <= 1'b1;
      o_hblank  <= 1'b0;
      o_vblank  <= 1'b0;
      o_hmax    <= 1'b0;
    end else begin
      o_hpos    <= hpos_next;
      o_vpos    <= vpos_next;
      // Sync pulses are active low
      o_hsync_n <= !(hpos_next >= pos_t'(H_SYNC_START) && hpos_next < pos_t'(H_SYNC_END));
      o_vsync_n <= !(vpos_next >= pos_t'(V_SYNC_START) && vpos_next < pos_t'(V_SYNC_END));
      o_hblank  <= (hpos_next >= pos_t'(H_VIEW));
      o_vblank  <= (vpos_next >= pos_t'(V_VIEW));
      o_hmax    <= (hpos_next == pos_t'(H_TOTAL - 1));
    end
  end

  // Counters never leave the raster
  a_pos_in_range: assert property (@(posedge clk) disable iff (i_reset)
    (o_hpos < pos_t'(H_TOTAL)) && (o_vpos < pos_t'(V_TOTAL)));

endmodule

`default_nettype wire

// ==== logic/rbz_tex_pkg.sv ====
`default_nettype none

package rbz_tex_pkg;

  import rbz_video_pkg::*;

  // Quad-SPI read sequence lengths, in sclk cycles
  localparam int TSPI_CMD_LEN      = 8;
  localparam int TSPI_ADDR_LEN     = 24;
  localparam int TSPI_DUMMY_LEN    = 8;
  localparam int TSPI_PREAMBLE_LEN = TSPI_CMD_LEN + TSPI_ADDR_LEN + TSPI_DUMMY_LEN;

  // One wall slice, two nibbles per texel
  localparam int TEXEL_COUNT       = 64;
  localparam int TSPI_READ_LEN     = TEXEL_COUNT * 2;
  localparam int TSPI_STREAM_LEN   = TSPI_PREAMBLE_LEN + TSPI_READ_LEN;

  // Stream starts so the first nibble lands on the first hblank pixel
  localparam int TSPI_HPOS_START   = H_VIEW - TSPI_PREAMBLE_LEN;

  // Flash command byte
  typedef enum logic [7:0] {
    QUAD_OUT_FAST_READ = 8'h6B
  } tex_cmd_e;

  // Phases of one flash read
  typedef enum logic [2:0] {
    IDLE,
    CMD,
    ADDR,
    DUMMY,
    READ
  } tspi_phase_e;

  typedef logic [23:0] tex_addr_t;
  // Texel index, also used for texu and texv
  typedef logic [5:0]  texel_idx_t;
  typedef logic [1:0]  wall_id_t;

endpackage

`default_nettype wire

// ==== logic/rbz_video_pkg.sv ====
`default_nettype none

package rbz_video_pkg;

  // 640x480 raster, horizontal timing in pixel clocks
  localparam int H_VIEW       = 640;
  localparam int H_TOTAL      = 800;
  localparam int H_SYNC_START = 656;
  // Exclusive end of hsync pulse
  localparam int H_SYNC_END   = 752;

  // Vertical timing in lines
  localparam int V_VIEW       = 480;
  localparam int V_TOTAL      = 525;
  localparam int V_SYNC_START = 490;
  // Exclusive end of vsync pulse
  localparam int V_SYNC_END   = 492;

  // Horizontal centre of the view, wall spans are centred here
  localparam int HALF_VIEW    = 320;

  // Fraction bits of the texture-v accumulator
  localparam int TEXV_FRAC_BITS = 10;

  typedef logic [9:0]  pos_t;
  // Packed as BBGGRR, MSB of each colour first
  typedef logic [5:0]  rgb_t;
  typedef logic [15:0] texv_acc_t;
  // Wall half-height in pixels
  typedef logic [9:0]  span_t;

endpackage

`default_nettype wire
